// File: design/alu.sv
`timescale 1ns/10ps
`include "core_settings.svh"

module alu
(
  input  isa_pkg::alu_op_t            op,
  input  logic [`CORE_WORD_WIDTH-1:0] a,
  input  logic [`CORE_WORD_WIDTH-1:0] b,
  output logic [`CORE_WORD_WIDTH-1:0] result,
  output logic                        zero
);

  localparam int sh_w = $clog2(`CORE_WORD_WIDTH);

  logic [sh_w-1:0] shamt;
  logic            lt;

  // Shift distance from the low bits of b only
  assign shamt = b[sh_w-1:0];
  assign lt    = $signed(a) < $signed(b);

  always_comb
  begin
    case (op)
      isa_pkg::alu_add: result = a + b;
      isa_pkg::alu_sub: result = a - b;
      isa_pkg::alu_and: result = a & b;
      isa_pkg::alu_or:  result = a | b;
      isa_pkg::alu_xor: result = a ^ b;
      // Zero-extended compare flag
      isa_pkg::alu_slt: result = {{(`CORE_WORD_WIDTH - 1){1'b0}}, lt};
      isa_pkg::alu_sll: result = a << shamt;
      // Logical, no sign fill
      isa_pkg::alu_srl: result = a >> shamt;
      default:          result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

// File: design/exec_pipe_top.sv
`timescale 1ns/10ps
`include "core_settings.svh"

module exec_pipe_top
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue_valid,
  input  pipe_pkg::issue_pkt_t issue_pkt,
  output logic                 credit_return,
  output logic                 wb_valid,
  output pipe_pkg::mem_wb_t    wb_rec
);

  logic                             head_valid;
  pipe_pkg::issue_pkt_t             head_pkt;
  logic                             pop;
  logic [`CORE_REG_INDEX_WIDTH-1:0] rs1_addr;
  logic [`CORE_REG_INDEX_WIDTH-1:0] rs2_addr;
  logic [`CORE_WORD_WIDTH-1:0]      rs1_data;
  logic [`CORE_WORD_WIDTH-1:0]      rs2_data;
  pipe_pkg::ex_mem_t                ex_mem_next;
  pipe_pkg::ex_mem_t                ex_mem_q;
  logic                             ex_active;
  logic                             ex_valid_q;
  pipe_pkg::mem_wb_t                mem_wb_next;
  logic                             mem_active;

  // Credit-managed entry point from the decoder
  issue_queue u_issue_queue
  (
    .clk           (clk),
    .rst           (rst),
    .push          (issue_valid),
    .push_pkt      (issue_pkt),
    .pop           (pop),
    .head_valid    (head_valid),
    .head_pkt      (head_pkt),
    .credit_return (credit_return)
  );

  // Written from the retire record one edge after it shows
  reg_file u_reg_file
  (
    .clk       (clk),
    .rst       (rst),
    .rd_addr_a (rs1_addr),
    .rd_addr_b (rs2_addr),
    .rd_data_a (rs1_data),
    .rd_data_b (rs2_data),
    .wr_en     (wb_valid && wb_rec.reg_write),
    .wr_addr   (wb_rec.rd),
    .wr_data   (wb_rec.wb_data)
  );

  exec_stage u_exec_stage
  (
    .head_valid  (head_valid),
    .head_pkt    (head_pkt),
    .pop         (pop),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .ex_mem_q    (ex_mem_q),
    .ex_valid_q  (ex_valid_q),
    .mem_wb_q    (wb_rec),
    .wb_valid    (wb_valid),
    .ex_mem_next (ex_mem_next),
    .ex_active   (ex_active)
  );

  // Execute/memory boundary
  stage_reg #(.payload_t(pipe_pkg::ex_mem_t)) u_ex_mem_reg
  (
    .clk        (clk),
    .rst        (rst),
    .active     (ex_active),
    .data_in    (ex_mem_next),
    .data_out   (ex_mem_q),
    .active_out (ex_valid_q)
  );

  mem_stage u_mem_stage
  (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (ex_valid_q),
    .ex_mem_q    (ex_mem_q),
    .mem_wb_next (mem_wb_next),
    .mem_active  (mem_active)
  );

  // Memory/writeback boundary, its outputs are the retire port
  stage_reg #(.payload_t(pipe_pkg::mem_wb_t)) u_mem_wb_reg
  (
    .clk        (clk),
    .rst        (rst),
    .active     (mem_active),
    .data_in    (mem_wb_next),
    .data_out   (wb_rec),
    .active_out (wb_valid)
  );

endmodule

// File: design/exec_stage.sv
`timescale 1ns/10ps
`include "core_settings.svh"

module exec_stage
(
  input  logic                             head_valid,
  input  pipe_pkg::issue_pkt_t             head_pkt,
  output logic                             pop,
  output logic [`CORE_REG_INDEX_WIDTH-1:0] rs1_addr,
  output logic [`CORE_REG_INDEX_WIDTH-1:0] rs2_addr,
  input  logic [`CORE_WORD_WIDTH-1:0]      rs1_data,
  input  logic [`CORE_WORD_WIDTH-1:0]      rs2_data,
  input  pipe_pkg::ex_mem_t                ex_mem_q,
  input  logic                             ex_valid_q,
  input  pipe_pkg::mem_wb_t                mem_wb_q,
  input  logic                             wb_valid,
  output pipe_pkg::ex_mem_t                ex_mem_next,
  output logic                             ex_active
);

  logic [`CORE_WORD_WIDTH-1:0] rs1_val;
  logic [`CORE_WORD_WIDTH-1:0] rs2_val;
  logic [`CORE_WORD_WIDTH-1:0] op_b;
  logic [`CORE_WORD_WIDTH-1:0] alu_result;
  logic                        alu_zero;
  logic                        is_alu;
  logic                        rs2_used;
  logic                        ex_fwd_ok;
  logic                        load_use;
  isa_pkg::alu_op_t            alu_op_sel;

  assign rs1_addr = head_pkt.rs1;
  assign rs2_addr = head_pkt.rs2;

  assign is_alu   = (head_pkt.kind == isa_pkg::op_alu);
  // Stores need rs2 as data, ALU ops only without an immediate
  assign rs2_used = (head_pkt.kind == isa_pkg::op_store) || (is_alu && !head_pkt.use_imm);

  // Only ALU results exist yet in the execute/memory register
  assign ex_fwd_ok = ex_valid_q && ex_mem_q.reg_write && (ex_mem_q.kind == isa_pkg::op_alu);

  // Operand a: ex/mem first, then mem/wb, then register file
  always_comb
  begin
    if (ex_fwd_ok && (ex_mem_q.rd == head_pkt.rs1))
      rs1_val = ex_mem_q.alu_result;
    else if (wb_valid && mem_wb_q.reg_write && (mem_wb_q.rd == head_pkt.rs1))
      rs1_val = mem_wb_q.wb_data;
    else
      rs1_val = rs1_data;
  end

  // Same priority for rs2, which also feeds store data
  always_comb
  begin
    if (ex_fwd_ok && (ex_mem_q.rd == head_pkt.rs2))
      rs2_val = ex_mem_q.alu_result;
    else if (wb_valid && mem_wb_q.reg_write && (mem_wb_q.rd == head_pkt.rs2))
      rs2_val = mem_wb_q.wb_data;
    else
      rs2_val = rs2_data;
  end

  // Load result not ready until it reaches mem/wb, so hold the head a cycle
  assign load_use = ex_valid_q && (ex_mem_q.kind == isa_pkg::op_load) && ex_mem_q.reg_write
                    && ((ex_mem_q.rd == head_pkt.rs1)
                        || (rs2_used && (ex_mem_q.rd == head_pkt.rs2)));

  // Bubble goes in whenever the head stays put
  assign pop       = head_valid && !load_use;
  assign ex_active = pop;

  // Memory ops form the address as rs1 + imm
  assign op_b       = (head_pkt.use_imm || !is_alu) ? head_pkt.imm : rs2_val;
  assign alu_op_sel = is_alu ? head_pkt.alu_op : isa_pkg::alu_add;

  alu u_alu
  (
    .op     (alu_op_sel),
    .a      (rs1_val),
    .b      (op_b),
    .result (alu_result),
    .zero   (alu_zero)
  );

  always_comb
  begin
    ex_mem_next.kind       = head_pkt.kind;
    // rd 0 never writes, later stages need not check it
    ex_mem_next.reg_write  = (head_pkt.kind != isa_pkg::op_store) && (head_pkt.rd != '0);
    ex_mem_next.rd         = head_pkt.rd;
    ex_mem_next.alu_result = alu_result;
    ex_mem_next.alu_zero   = alu_zero;
    ex_mem_next.store_data = rs2_val;
  end

endmodule

// File: design/isa_pkg.sv
`include "core_settings.svh"

package isa_pkg;

  // ALU function select
  // Shifts take the low 5 bits of operand b
  typedef enum logic [2:0]
  {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    alu_slt = 3'd5,  // signed compare
    alu_sll = 3'd6,
    alu_srl = 3'd7
  } alu_op_t;

  // Operation class seen by the back end
  // Loads and stores always compute rs1 + imm as the word address
  typedef enum logic [1:0]
  {
    op_alu   = 2'd0,
    op_load  = 2'd1,
    op_store = 2'd2
  } op_kind_t;

endpackage

// File: design/issue_queue.sv
`timescale 1ns/10ps
`include "core_settings.svh"

module issue_queue
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push,
  input  pipe_pkg::issue_pkt_t push_pkt,
  input  logic                 pop,
  output logic                 head_valid,
  output pipe_pkg::issue_pkt_t head_pkt,
  output logic                 credit_return
);

  localparam int ptr_w = $clog2(`CORE_QUEUE_DEPTH);
  localparam int cnt_w = $clog2(`CORE_QUEUE_DEPTH + 1);

  // Entry storage, contents only matter while counted
  pipe_pkg::issue_pkt_t entries [`CORE_QUEUE_DEPTH];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_pop;

  // No bypass, a fresh push shows at the head one edge later
  assign head_valid = (count != '0);
  assign head_pkt   = entries[rd_ptr];
  assign do_pop     = pop && head_valid;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      entries[wr_ptr] <= push_pkt;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end
    else
    begin
      // Pointers wrap at the depth, which need not be a power of two
      if (push)
      begin
        wr_ptr <= (wr_ptr == ptr_w'(`CORE_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= (rd_ptr == ptr_w'(`CORE_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Sender credits keep push away from a full queue
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back per released entry
      credit_return <= do_pop;
    end
  end

endmodule

// File: design/mem_stage.sv
`timescale 1ns/10ps
`include "core_settings.svh"

module mem_stage
(
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  pipe_pkg::ex_mem_t ex_mem_q,
  output pipe_pkg::mem_wb_t mem_wb_next,
  output logic              mem_active
);

  localparam int addr_w = $clog2(`CORE_MEM_WORDS);

  logic [`CORE_WORD_WIDTH-1:0] mem [`CORE_MEM_WORDS];
  logic [addr_w-1:0]           addr;
  logic                        is_load;

  // Word index, wraps at the memory depth
  assign addr    = ex_mem_q.alu_result[addr_w-1:0];
  assign is_load = (ex_mem_q.kind == isa_pkg::op_load);

  // Store lands on the edge that moves it into mem/wb
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `CORE_MEM_WORDS; i++)
      begin
        mem[i] <= '0;
      end
    end
    else if (in_valid && (ex_mem_q.kind == isa_pkg::op_store))
    begin
      mem[addr] <= ex_mem_q.store_data;
    end
  end

  always_comb
  begin
    mem_wb_next.reg_write = ex_mem_q.reg_write;
    mem_wb_next.rd        = ex_mem_q.rd;
    mem_wb_next.wb_data   = is_load ? mem[addr] : ex_mem_q.alu_result;  // async read
    mem_wb_next.was_load  = is_load;
  end

  assign mem_active = in_valid;

endmodule

// File: design/pipe_pkg.sv
`include "core_settings.svh"

package pipe_pkg;

  // Decoded operation as delivered by the decoder
  typedef struct packed
  {
    isa_pkg::op_kind_t              kind;
    isa_pkg::alu_op_t               alu_op;
    logic [`CORE_REG_INDEX_WIDTH-1:0] rd;
    logic [`CORE_REG_INDEX_WIDTH-1:0] rs1;
    logic [`CORE_REG_INDEX_WIDTH-1:0] rs2;
    logic                           use_imm;
    logic [`CORE_WORD_WIDTH-1:0]      imm;
  } issue_pkt_t;

  // Execute to memory payload
  // reg_write is already cleared for rd 0
  typedef struct packed
  {
    isa_pkg::op_kind_t              kind;
    logic                           reg_write;
    logic [`CORE_REG_INDEX_WIDTH-1:0] rd;
    logic [`CORE_WORD_WIDTH-1:0]      alu_result;
    logic                           alu_zero;
    logic [`CORE_WORD_WIDTH-1:0]      store_data;
  } ex_mem_t;

  // Memory to writeback payload, doubles as the retire record
  typedef struct packed
  {
    logic                           reg_write;
    logic [`CORE_REG_INDEX_WIDTH-1:0] rd;
    logic [`CORE_WORD_WIDTH-1:0]      wb_data;
    logic                           was_load;
  } mem_wb_t;

endpackage

// File: design/reg_file.sv
`timescale 1ns/10ps
`include "core_settings.svh"

module reg_file
(
  input  logic                             clk,
  input  logic                             rst,
  input  logic [`CORE_REG_INDEX_WIDTH-1:0] rd_addr_a,
  input  logic [`CORE_REG_INDEX_WIDTH-1:0] rd_addr_b,
  output logic [`CORE_WORD_WIDTH-1:0]      rd_data_a,
  output logic [`CORE_WORD_WIDTH-1:0]      rd_data_b,
  input  logic                             wr_en,
  input  logic [`CORE_REG_INDEX_WIDTH-1:0] wr_addr,
  input  logic [`CORE_WORD_WIDTH-1:0]      wr_data
);

  logic [`CORE_WORD_WIDTH-1:0] regs [`CORE_NUM_REGS];

  // Combinational read ports
  // Register 0 stays zero since writes to it never arrive
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < `CORE_NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_en)
    begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

// File: design/stage_reg.sv
`timescale 1ns/10ps
`include "core_settings.svh"

module stage_reg #(
  parameter type payload_t = logic
)
(
  input  logic     clk,
  input  logic     rst,
  input  logic     active,
  input  payload_t data_in,
  output payload_t data_out,
  output logic     active_out
);

  // Payload holds its last value across bubbles
  always_ff @(posedge clk)
  begin
    if (active)
    begin
      data_out <= data_in;
    end
  end

  // Valid flag tracks active every cycle
  always_ff @(posedge clk)
  begin
    if (rst)
      active_out <= 1'b0;
    else
      active_out <= active;
  end

endmodule

// File: include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath word, also the immediate width
`define CORE_WORD_WIDTH 32

// Register index and register count
// Register 0 always reads as zero
`define CORE_REG_INDEX_WIDTH 5
`define CORE_NUM_REGS 32

// Data memory depth in words
// Addresses are word indexes, wrapped to this depth
`define CORE_MEM_WORDS 64

// Issue queue entries, equal to the sender's starting credit count
`define CORE_QUEUE_DEPTH 4

`endif

// File: project.f
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/issue_queue.sv
design/reg_file.sv
design/alu.sv
design/exec_stage.sv
design/stage_reg.sv
design/mem_stage.sv
design/exec_pipe_top.sv
tb/exec_pipe_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator and run it
# A failing check ends the run through $fatal, which gives a non-zero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  -f project.f \
  --top-module exec_pipe_tb \
  -o exec_pipe_sim

./obj_dir/exec_pipe_sim

// File: tb/exec_pipe_tb.sv
`timescale 1ns/10ps
`include "core_settings.svh"

module exec_pipe_tb;

  localparam int queue_depth = `CORE_QUEUE_DEPTH;
  localparam int idx_w       = `CORE_REG_INDEX_WIDTH;
  localparam int wait_limit  = 200;
  localparam int random_ops  = 300;

  typedef logic [idx_w-1:0]            idx_t;
  typedef logic [`CORE_WORD_WIDTH-1:0] word_t;

  logic                 clk         = 1'b0;
  logic                 rst         = 1'b1;
  logic                 issue_valid = 1'b0;
  pipe_pkg::issue_pkt_t issue_pkt   = '0;
  logic                 credit_return;
  logic                 wb_valid;
  pipe_pkg::mem_wb_t    wb_rec;

  // Sequential model state updated in issue order
  word_t model_regs [`CORE_NUM_REGS];
  word_t model_mem [`CORE_MEM_WORDS];
  pipe_pkg::mem_wb_t exp_q [$];

  // Credits held by the sender are depth - sent + returned
  int sent_count     = 0;
  int returned_count = 0;
  int retired_count  = 0;

  exec_pipe_top i_dut
  (
    .clk           (clk),
    .rst           (rst),
    .issue_valid   (issue_valid),
    .issue_pkt     (issue_pkt),
    .credit_return (credit_return),
    .wb_valid      (wb_valid),
    .wb_rec        (wb_rec)
  );

  always #5 clk = ~clk;

  task automatic halt_on_error();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic mismatch_stop(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    halt_on_error();
  endtask

  task automatic abort_run(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    halt_on_error();
  endtask

  function automatic int credits_now();
    return queue_depth - sent_count + returned_count;
  endfunction

  // Reference ALU over the eight operations
  function automatic word_t ref_alu(isa_pkg::alu_op_t op, word_t a, word_t b);
    word_t r;
    case (op)
      isa_pkg::alu_add: r = a + b;
      isa_pkg::alu_sub: r = a - b;
      isa_pkg::alu_and: r = a & b;
      isa_pkg::alu_or:  r = a | b;
      isa_pkg::alu_xor: r = a ^ b;
      isa_pkg::alu_slt: r = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
      isa_pkg::alu_sll: r = a << b[4:0];
      isa_pkg::alu_srl: r = a >> b[4:0];
      default:          r = '0;
    endcase
    return r;
  endfunction

  // Applies one operation to the model and returns its retire record
  function automatic pipe_pkg::mem_wb_t model_issue(pipe_pkg::issue_pkt_t pkt);
    pipe_pkg::mem_wb_t rec;
    word_t             a;
    word_t             b;
    word_t             sum;
    int                addr;
    a    = (pkt.rs1 == '0) ? '0 : model_regs[pkt.rs1];
    b    = (pkt.rs2 == '0) ? '0 : model_regs[pkt.rs2];
    sum  = a + pkt.imm;
    // Word address wraps at the memory depth
    addr = int'(sum % `CORE_MEM_WORDS);
    rec.rd        = pkt.rd;
    rec.reg_write = (pkt.kind != isa_pkg::op_store) && (pkt.rd != '0);
    rec.was_load  = (pkt.kind == isa_pkg::op_load);
    case (pkt.kind)
      isa_pkg::op_load:
        rec.wb_data = model_mem[addr];
      isa_pkg::op_store:
      begin
        rec.wb_data     = sum;
        model_mem[addr] = b;
      end
      default:
        rec.wb_data = ref_alu(pkt.alu_op, a, pkt.use_imm ? pkt.imm : b);
    endcase
    if (rec.reg_write)
      model_regs[pkt.rd] = rec.wb_data;
    return rec;
  endfunction

  function automatic pipe_pkg::issue_pkt_t make_pkt(isa_pkg::op_kind_t kind,
                                                    isa_pkg::alu_op_t op, int rd, int rs1,
                                                    int rs2, logic use_imm, word_t imm);
    pipe_pkg::issue_pkt_t pkt;
    pkt.kind    = kind;
    pkt.alu_op  = op;
    pkt.rd      = idx_t'(rd);
    pkt.rs1     = idx_t'(rs1);
    pkt.rs2     = idx_t'(rs2);
    pkt.use_imm = use_imm;
    pkt.imm     = imm;
    return pkt;
  endfunction

  // Sends one operation once a credit is held, then records the expected retire
  task automatic issue_op(input pipe_pkg::issue_pkt_t pkt);
    int waited;
    waited = 0;
    while (credits_now() <= 0)
    begin
      issue_valid <= 1'b0;
      @(posedge clk);
      waited++;
      if (waited > wait_limit)
        abort_run("no credit came back before the timeout");
    end
    issue_valid <= 1'b1;
    issue_pkt   <= pkt;
    sent_count++;
    exp_q.push_back(model_issue(pkt));
    @(posedge clk);
  endtask

  task automatic reg_alu(input isa_pkg::alu_op_t op, input int rd, input int rs1, input int rs2);
    issue_op(make_pkt(isa_pkg::op_alu, op, rd, rs1, rs2, 1'b0, '0));
  endtask

  task automatic imm_alu(input isa_pkg::alu_op_t op, input int rd, input int rs1,
                         input word_t imm);
    issue_op(make_pkt(isa_pkg::op_alu, op, rd, rs1, 0, 1'b1, imm));
  endtask

  task automatic load_word(input int rd, input int rs1, input word_t imm);
    issue_op(make_pkt(isa_pkg::op_load, isa_pkg::alu_add, rd, rs1, 0, 1'b1, imm));
  endtask

  task automatic store_word(input int rs2, input int rs1, input word_t imm);
    issue_op(make_pkt(isa_pkg::op_store, isa_pkg::alu_add, 0, rs1, rs2, 1'b1, imm));
  endtask

  task automatic idle_cycles(input int n);
    issue_valid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  // Random op over registers 0 to 7 and memory words 0 to 15 through r0 plus offset
  function automatic pipe_pkg::issue_pkt_t random_op();
    pipe_pkg::issue_pkt_t pkt;
    int                   pick;
    pick = int'($urandom_range(0, 3));
    pkt  = make_pkt(isa_pkg::op_alu, isa_pkg::alu_op_t'(3'($urandom_range(0, 7))),
                    int'($urandom_range(0, 7)), int'($urandom_range(0, 7)),
                    int'($urandom_range(0, 7)), 1'($urandom_range(0, 1)), $urandom());
    if (pick >= 2)
    begin
      pkt.kind    = (pick == 2) ? isa_pkg::op_load : isa_pkg::op_store;
      pkt.alu_op  = isa_pkg::alu_add;
      pkt.rs1     = '0;
      pkt.use_imm = 1'b1;
      pkt.imm     = word_t'($urandom_range(0, 15));
    end
    return pkt;
  endfunction

  // Waits until every issued operation has retired
  task automatic drain_pipeline();
    int waited;
    waited = 0;
    issue_valid <= 1'b0;
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
      waited++;
      if (waited > wait_limit)
        abort_run("pipeline did not drain before the timeout");
    end
  endtask

  // Outputs come out of reset low
  assert property (@(posedge clk) rst |=> (!credit_return && !wb_valid))
    else abort_run("credit_return or wb_valid high right after reset");

  // Register 0 never gets a write
  assert property (@(posedge clk) disable iff (rst)
                   (wb_valid && (wb_rec.rd == '0)) |-> !wb_rec.reg_write)
    else mismatch_stop("retire to register 0 has reg_write set");

  // Retire and credit monitor on the falling clock edge
  always @(negedge clk)
  begin
    pipe_pkg::mem_wb_t expected;
    if (!rst)
    begin
      if (credit_return)
        returned_count++;
      assert ((credits_now() >= 0) && (credits_now() <= queue_depth))
        else abort_run($sformatf("credit count %0d is out of range", credits_now()));
      if (wb_valid)
      begin
        if (exp_q.size() == 0)
          abort_run("an operation retired with none outstanding");
        else
        begin
          expected = exp_q.pop_front();
          retired_count++;
          assert (wb_rec == expected)
            else mismatch_stop($sformatf(
              "retire %0d got rd %0d we %0b data %08h ld %0b want rd %0d we %0b data %08h ld %0b",
              retired_count, wb_rec.rd, wb_rec.reg_write, wb_rec.wb_data, wb_rec.was_load,
              expected.rd, expected.reg_write, expected.wb_data, expected.was_load));
        end
      end
    end
  end

  initial
  begin
    void'($urandom(32'h7796_7058));
    for (int i = 0; i < `CORE_NUM_REGS; i++)
      model_regs[i] = '0;
    for (int i = 0; i < `CORE_MEM_WORDS; i++)
      model_mem[i] = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Known register values then every ALU function with both operand kinds
    imm_alu(isa_pkg::alu_add, 1, 0, 32'h1234_5678);
    imm_alu(isa_pkg::alu_add, 2, 0, 32'hFFFF_FFFB);
    imm_alu(isa_pkg::alu_add, 3, 0, 32'd3);
    for (int k = 0; k < 8; k++)
    begin
      reg_alu(isa_pkg::alu_op_t'(3'(k)), 4, 1, 2);
      reg_alu(isa_pkg::alu_op_t'(3'(k)), 5, 2, 3);
      imm_alu(isa_pkg::alu_op_t'(3'(k)), 6, 1, 32'h0000_0F0F);
    end

    // Dependent ops at distances 1, 2 and 3
    for (int d = 1; d <= 3; d++)
    begin
      imm_alu(isa_pkg::alu_add, 7, 7, word_t'(11 * d));
      for (int f = 1; f < d; f++)
        imm_alu(isa_pkg::alu_xor, 8, 3, 32'h55);
      reg_alu(isa_pkg::alu_sub, 6, 7, 1);
      reg_alu(isa_pkg::alu_add, 5, 6, 6);
    end

    // Store then load with a load-use right behind
    store_word(1, 0, 32'd5);
    load_word(9, 0, 32'd5);
    reg_alu(isa_pkg::alu_add, 10, 9, 9);
    store_word(2, 3, 32'd6);
    load_word(11, 0, 32'd9);
    imm_alu(isa_pkg::alu_or, 12, 11, 32'h100);
    load_word(13, 0, 32'd9);
    store_word(13, 0, 32'd12);
    load_word(14, 0, 32'd12);
    // Never written words including a wrapped address
    load_word(15, 0, 32'd40);
    load_word(16, 0, 32'd67);

    // Writes aimed at register 0 are dropped
    imm_alu(isa_pkg::alu_add, 0, 1, 32'd1);
    reg_alu(isa_pkg::alu_or, 17, 0, 0);
    load_word(0, 0, 32'd5);
    reg_alu(isa_pkg::alu_add, 18, 0, 1);

    for (int n = 0; n < random_ops; n++)
    begin
      issue_op(random_op());
      if ($urandom_range(0, 9) == 0)
        idle_cycles(int'($urandom_range(1, 3)));
    end

    drain_pipeline();
    // Each credit returns a cycle before its operation retires
    if (credits_now() == queue_depth)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      abort_run("not all credits came back by the last retire");
    end
  end

endmodule
